// ==== hdl/adc_bridge_pkg.sv ====
package adc_bridge_pkg;

   // one byte on the ft245 data bus
   typedef logic [7:0] byte_t;

   // mcp3008 conversion code, 10 bits
   typedef logic [9:0] adc_code_t;

   // single-ended input select, ch0..ch7
   typedef logic [2:0] adc_channel_t;

   // conversion result as handed to the controller
   typedef struct packed {
      adc_channel_t channel;
      adc_code_t    code;
   } adc_result_t;

   // command controller states
   typedef enum logic [2:0] {
      ctrl_idle,
      ctrl_eval,
      ctrl_convert,
      ctrl_push_low,
      ctrl_push_high
   } ctrl_state_t;

   // upper five bits of an adc read command, 0x10..0x17
   localparam logic [4:0] CMD_ADC_OPCODE = 5'b00010;

   // clk cycles per dclk half period
   localparam int DCLK_HALF = 4;

   // dclk periods in one conversion frame
   localparam int ADC_FRAME_CLOCKS = 17;

   // transmit fifo geometry
   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_AW = 3;

endpackage

// ==== hdl/ft245_port.sv ====
`timescale 1ns/100ps

module ft245_port (
   input  logic                       clk,
   input  logic                       reset,
   inout  wire adc_bridge_pkg::byte_t ft_bus,
   input  logic                       ft_rxf_n,
   input  logic                       ft_txe_n,
   output logic                       ft_rd_n,
   output logic                       ft_wr_n,
   output logic                       ft_oe_n,
   input  logic                       rx_ready,
   output logic                       rx_valid,
   output adc_bridge_pkg::byte_t      rx_data,
   input  adc_bridge_pkg::byte_t      tx_data,
   input  logic                       tx_empty,
   output logic                       tx_pop
);

   // read sequence: oe_n low first, then rd_n low while oe_n stays low
   typedef enum logic [1:0] {
      port_idle,
      port_oe,
      port_read
   } port_state_t;

   port_state_t state;
   logic        write_active;
   logic        read_start;

   // a response byte sits at the fifo head and no read is in flight
   assign write_active = (state == port_idle) && !tx_empty;

   // start a read only if the controller wants a byte and the host has one
   // skip the cycle of rx_valid, controller is still idle there
   // a byte the host can accept right now wins over the read
   assign read_start = (state == port_idle) && rx_ready && !rx_valid && !ft_rxf_n &&
                       (tx_empty || ft_txe_n);

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= port_idle;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         case (state)
            port_idle: begin
               if (read_start) begin
                  state <= port_oe;
               end
            end
            // host turns its bus driver on during this cycle
            port_oe: begin
               state <= port_read;
            end
            // rd_n low; byte taken on the edge with rxf_n low
            port_read: begin
               state <= port_idle;
               if (!ft_rxf_n) begin
                  rx_valid <= 1'b1;
               end
            end
            default: begin
               state <= port_idle;
            end
         endcase
      end
   end

   // capture the host byte, one byte per request
   always_ff @(posedge clk) begin
      if ((state == port_read) && !ft_rxf_n) begin
         rx_data <= ft_bus;
      end
   end

   // bus strobes straight from the sequencer state
   assign ft_oe_n = !((state == port_oe) || (state == port_read));
   assign ft_rd_n = !(state == port_read);

   // wr_n only ever low in idle, so never together with oe_n
   assign ft_wr_n = !write_active;

   // host takes the byte on each edge with wr_n and txe_n low
   assign tx_pop = write_active && !ft_txe_n;

   // drive only while writing, oe_n is high then
   assign ft_bus = write_active ? tx_data : 'z;

endmodule

// ==== hdl/byte_fifo.sv ====
`timescale 1ns/100ps

module byte_fifo (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  push,
   input  adc_bridge_pkg::byte_t push_data,
   output logic                  full,
   input  logic                  pop,
   output adc_bridge_pkg::byte_t pop_data,
   output logic                  empty
);

   // storage, no reset on the data
   adc_bridge_pkg::byte_t mem [adc_bridge_pkg::FIFO_DEPTH];

   logic [adc_bridge_pkg::FIFO_AW-1:0] wr_ptr;
   logic [adc_bridge_pkg::FIFO_AW-1:0] rd_ptr;

   // one extra bit so a full fifo can be told from an empty one
   logic [adc_bridge_pkg::FIFO_AW:0] count;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // pointers wrap on their own, depth is a power of two
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10: begin
               count <= count + 1'b1;
            end
            2'b01: begin
               count <= count - 1'b1;
            end
            // push and pop together leave the level alone
            default: begin
               count <= count;
            end
         endcase
      end
   end

   // show-ahead, head entry always on the output
   assign pop_data = mem[rd_ptr];

   assign full  = (count == (adc_bridge_pkg::FIFO_AW + 1)'(adc_bridge_pkg::FIFO_DEPTH));
   assign empty = (count == '0);

endmodule

// ==== hdl/mcp3008_reader.sv ====
`timescale 1ns/100ps

module mcp3008_reader (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         start,
   input  adc_bridge_pkg::adc_channel_t channel,
   output logic                         done,
   output adc_bridge_pkg::adc_result_t  result,
   output logic                         dclk,
   input  logic                         dout,
   output logic                         din,
   output logic                         cs_n
);

   // clk count within one dclk half period
   logic [$clog2(adc_bridge_pkg::DCLK_HALF)-1:0] div_cnt;

   // dclk period number, 0 is the lead-in after cs_n falls
   logic [$clog2(adc_bridge_pkg::ADC_FRAME_CLOCKS + 1)-1:0] period;

   logic                         busy;
   logic                         half_end;
   logic [4:0]                   cmd_sr;
   adc_bridge_pkg::adc_code_t    code_sr;
   adc_bridge_pkg::adc_channel_t chan_q;

   assign half_end = (div_cnt == $bits(div_cnt)'(adc_bridge_pkg::DCLK_HALF - 1));

   always_ff @(posedge clk) begin
      if (reset) begin
         busy    <= 1'b0;
         cs_n    <= 1'b1;
         dclk    <= 1'b1;
         din     <= 1'b0;
         done    <= 1'b0;
         div_cnt <= '0;
         period  <= '0;
      end else begin
         done <= 1'b0;
         if (!busy) begin
            // select the chip, dclk stays high for one lead-in cycle
            if (start) begin
               busy   <= 1'b1;
               cs_n   <= 1'b0;
               period <= '0;
            end
         end else if (period == '0) begin
            // first falling edge, start bit goes out
            dclk    <= 1'b0;
            din     <= cmd_sr[4];
            period  <= 1'b1;
            div_cnt <= '0;
         end else if (!half_end) begin
            div_cnt <= div_cnt + 1'b1;
         end else begin
            div_cnt <= '0;
            if (!dclk) begin
               // rising edge, the adc samples din here
               dclk <= 1'b1;
            end else if (period == $bits(period)'(adc_bridge_pkg::ADC_FRAME_CLOCKS)) begin
               // frame over, deselect and report
               busy <= 1'b0;
               cs_n <= 1'b1;
               din  <= 1'b0;
               done <= 1'b1;
            end else begin
               // falling edge, next command bit or zero
               dclk   <= 1'b0;
               din    <= cmd_sr[4];
               period <= period + 1'b1;
            end
         end
      end
   end

   // command bits and captured code, no reset needed
   always_ff @(posedge clk) begin
      if (!busy && start) begin
         // start, single-ended, d2 d1 d0
         cmd_sr <= {2'b11, channel};
         chan_q <= channel;
      end else if (busy && ((period == '0) || (half_end && dclk))) begin
         // shift on every falling edge, zeros follow the channel bits
         cmd_sr <= {cmd_sr[3:0], 1'b0};
      end
      // code bits b9..b0 on the rising edges of periods 8 to 17
      if (busy && half_end && !dclk && (period >= $bits(period)'(8))) begin
         code_sr <= {code_sr[8:0], dout};
      end
   end

   // result stays put until the next frame ends
   always_ff @(posedge clk) begin
      if (busy && half_end && dclk &&
          (period == $bits(period)'(adc_bridge_pkg::ADC_FRAME_CLOCKS))) begin
         result.channel <= chan_q;
         result.code    <= code_sr;
      end
   end

endmodule

// ==== hdl/cmd_controller.sv ====
`timescale 1ns/100ps

module cmd_controller (
   input  logic                         clk,
   input  logic                         reset,
   output logic                         rx_ready,
   input  logic                         rx_valid,
   input  adc_bridge_pkg::byte_t        rx_data,
   output logic                         adc_start,
   output adc_bridge_pkg::adc_channel_t adc_channel,
   input  logic                         adc_done,
   input  adc_bridge_pkg::adc_result_t  adc_result,
   output logic                         fifo_push,
   output adc_bridge_pkg::byte_t        fifo_data,
   input  logic                         fifo_full
);

   adc_bridge_pkg::ctrl_state_t state;

   // last command byte from the host
   adc_bridge_pkg::byte_t cmd;

   logic cmd_is_adc;

   // 0x10..0x17, low three bits pick the channel
   assign cmd_is_adc = (cmd[7:3] == adc_bridge_pkg::CMD_ADC_OPCODE);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= adc_bridge_pkg::ctrl_idle;
      end else begin
         case (state)
            adc_bridge_pkg::ctrl_idle: begin
               if (rx_valid) begin
                  state <= adc_bridge_pkg::ctrl_eval;
               end
            end
            // unknown bytes are dropped here
            adc_bridge_pkg::ctrl_eval: begin
               if (cmd_is_adc) begin
                  state <= adc_bridge_pkg::ctrl_convert;
               end else begin
                  state <= adc_bridge_pkg::ctrl_idle;
               end
            end
            adc_bridge_pkg::ctrl_convert: begin
               if (adc_done) begin
                  state <= adc_bridge_pkg::ctrl_push_low;
               end
            end
            // each push state waits out a full fifo
            adc_bridge_pkg::ctrl_push_low: begin
               if (!fifo_full) begin
                  state <= adc_bridge_pkg::ctrl_push_high;
               end
            end
            adc_bridge_pkg::ctrl_push_high: begin
               if (!fifo_full) begin
                  state <= adc_bridge_pkg::ctrl_idle;
               end
            end
            default: begin
               state <= adc_bridge_pkg::ctrl_idle;
            end
         endcase
      end
   end

   // command register, loaded on the port strobe
   always_ff @(posedge clk) begin
      if ((state == adc_bridge_pkg::ctrl_idle) && rx_valid) begin
         cmd <= rx_data;
      end
   end

   // new commands only accepted in idle
   assign rx_ready = (state == adc_bridge_pkg::ctrl_idle);

   // single cycle start, eval lasts one cycle
   assign adc_start   = (state == adc_bridge_pkg::ctrl_eval) && cmd_is_adc;
   assign adc_channel = cmd[2:0];

   // response bytes
   // low: code[7:0]
   // high: channel in 6:4, code[9:8] in 1:0
   always_comb begin
      fifo_push = 1'b0;
      fifo_data = '0;
      case (state)
         adc_bridge_pkg::ctrl_push_low: begin
            fifo_push = !fifo_full;
            fifo_data = adc_result.code[7:0];
         end
         adc_bridge_pkg::ctrl_push_high: begin
            fifo_push = !fifo_full;
            fifo_data = {1'b0, adc_result.channel, 2'b00, adc_result.code[9:8]};
         end
         default: begin
            fifo_push = 1'b0;
         end
      endcase
   end

endmodule

// ==== hdl/adc_bridge_top.sv ====
`timescale 1ns/100ps

module adc_bridge_top (
   input  logic                       clk,
   input  logic                       reset,
   inout  wire adc_bridge_pkg::byte_t ft_bus,
   input  logic                       ft_rxf_n,
   input  logic                       ft_txe_n,
   output logic                       ft_rd_n,
   output logic                       ft_wr_n,
   output logic                       ft_oe_n,
   output logic                       mcp_dclk,
   input  logic                       mcp_dout,
   output logic                       mcp_din,
   output logic                       mcp_cs_n
);

   // port to controller
   logic                  rx_ready;
   logic                  rx_valid;
   adc_bridge_pkg::byte_t rx_data;

   // fifo to port
   adc_bridge_pkg::byte_t tx_data;
   logic                  tx_empty;
   logic                  tx_pop;

   // controller to fifo
   logic                  fifo_push;
   adc_bridge_pkg::byte_t fifo_data;
   logic                  fifo_full;

   // controller and adc reader
   logic                         adc_start;
   adc_bridge_pkg::adc_channel_t adc_channel;
   logic                         adc_done;
   adc_bridge_pkg::adc_result_t  adc_result;

   ft245_port u_port (
      .clk      (clk),
      .reset    (reset),
      .ft_bus   (ft_bus),
      .ft_rxf_n (ft_rxf_n),
      .ft_txe_n (ft_txe_n),
      .ft_rd_n  (ft_rd_n),
      .ft_wr_n  (ft_wr_n),
      .ft_oe_n  (ft_oe_n),
      .rx_ready (rx_ready),
      .rx_valid (rx_valid),
      .rx_data  (rx_data),
      .tx_data  (tx_data),
      .tx_empty (tx_empty),
      .tx_pop   (tx_pop)
   );

   // response bytes toward the host
   byte_fifo u_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (fifo_push),
      .push_data (fifo_data),
      .full      (fifo_full),
      .pop       (tx_pop),
      .pop_data  (tx_data),
      .empty     (tx_empty)
   );

   mcp3008_reader u_adc (
      .clk     (clk),
      .reset   (reset),
      .start   (adc_start),
      .channel (adc_channel),
      .done    (adc_done),
      .result  (adc_result),
      .dclk    (mcp_dclk),
      .dout    (mcp_dout),
      .din     (mcp_din),
      .cs_n    (mcp_cs_n)
   );

   cmd_controller u_ctrl (
      .clk         (clk),
      .reset       (reset),
      .rx_ready    (rx_ready),
      .rx_valid    (rx_valid),
      .rx_data     (rx_data),
      .adc_start   (adc_start),
      .adc_channel (adc_channel),
      .adc_done    (adc_done),
      .adc_result  (adc_result),
      .fifo_push   (fifo_push),
      .fifo_data   (fifo_data),
      .fifo_full   (fifo_full)
   );

endmodule

// ==== sim/adc_bridge_asserts.sv ====
`timescale 1ns/100ps

module adc_bridge_asserts (
   input logic                        clk,
   input logic                        reset,
   input logic                        ft_rd_n,
   input logic                        ft_wr_n,
   input logic                        ft_oe_n,
   input logic                        mcp_dclk,
   input logic                        mcp_cs_n,
   input logic                        fifo_push,
   input logic                        fifo_full,
   input adc_bridge_pkg::ctrl_state_t ctrl_state
);

   // count of failed assertions for the testbench
   int fail_count = 0;

   // rd_n only inside an oe_n window
   a_rd_inside_oe: assert property (@(posedge clk) disable iff (reset)
      !ft_rd_n |-> !ft_oe_n)
      else begin
         $error("ft_rd_n low while ft_oe_n high");
         fail_count++;
      end

   // host drives the bus while oe_n is low so no write then
   a_no_wr_during_oe: assert property (@(posedge clk) disable iff (reset)
      !(!ft_wr_n && !ft_oe_n))
      else begin
         $error("ft_wr_n and ft_oe_n low together");
         fail_count++;
      end

   // spi clock parks high between frames
   a_dclk_idle_high: assert property (@(posedge clk) disable iff (reset)
      mcp_cs_n |-> mcp_dclk)
      else begin
         $error("mcp_dclk low while mcp_cs_n high");
         fail_count++;
      end

   a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
      !(fifo_push && fifo_full))
      else begin
         $error("fifo push while fifo full");
         fail_count++;
      end

   // five legal states in a 3-bit encoding
   a_state_range: assert property (@(posedge clk) disable iff (reset)
      ctrl_state <= adc_bridge_pkg::ctrl_push_high)
      else begin
         $error("controller state out of range");
         fail_count++;
      end

endmodule

bind adc_bridge_top adc_bridge_asserts u_asserts (
   .clk        (clk),
   .reset      (reset),
   .ft_rd_n    (ft_rd_n),
   .ft_wr_n    (ft_wr_n),
   .ft_oe_n    (ft_oe_n),
   .mcp_dclk   (mcp_dclk),
   .mcp_cs_n   (mcp_cs_n),
   .fifo_push  (fifo_push),
   .fifo_full  (fifo_full),
   .ctrl_state (u_ctrl.state)
);

// ==== sim/tb_adc_bridge.sv ====
`timescale 1ns/100ps

module tb_adc_bridge;

   localparam int WAIT_LIMIT = 2000;
   // adc start pulse to done pulse
   localparam int CONV_CYCLES =
      adc_bridge_pkg::ADC_FRAME_CLOCKS * 2 * adc_bridge_pkg::DCLK_HALF + 2;
   // mcp3008 sends b9 in period 8 after the command bits and the null bit
   localparam int FIRST_CODE_PERIOD = 8;
   localparam int CMD_BITS = 5;

   logic                  clk;
   logic                  reset;
   wire  adc_bridge_pkg::byte_t ft_bus;
   logic                  ft_rxf_n;
   logic                  ft_txe_n;
   logic                  ft_rd_n;
   logic                  ft_wr_n;
   logic                  ft_oe_n;
   logic                  mcp_dclk;
   logic                  mcp_dout;
   logic                  mcp_din;
   logic                  mcp_cs_n;

   // host side queues
   adc_bridge_pkg::byte_t        cmd_q[$];
   adc_bridge_pkg::byte_t        rx_q[$];
   adc_bridge_pkg::byte_t        host_byte;
   // channels commanded and what the adc model saw and sent
   adc_bridge_pkg::adc_channel_t exp_chan_q[$];
   adc_bridge_pkg::adc_channel_t frame_chan_q[$];
   adc_bridge_pkg::adc_code_t    frame_code_q[$];

   // adc model state
   logic [31:0]                  lcg_state;
   adc_bridge_pkg::adc_code_t    frame_code;
   logic [CMD_BITS-1:0]          din_bits;
   logic                         prev_cs_n;
   logic                         prev_dclk;
   int                           rise_cnt;
   int                           fall_cnt;
   int                           conv_cnt;

   adc_bridge_top u_dut (
      .clk      (clk),
      .reset    (reset),
      .ft_bus   (ft_bus),
      .ft_rxf_n (ft_rxf_n),
      .ft_txe_n (ft_txe_n),
      .ft_rd_n  (ft_rd_n),
      .ft_wr_n  (ft_wr_n),
      .ft_oe_n  (ft_oe_n),
      .mcp_dclk (mcp_dclk),
      .mcp_dout (mcp_dout),
      .mcp_din  (mcp_din),
      .mcp_cs_n (mcp_cs_n)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ft232h drives the bus whenever the fpga pulls oe_n low
   assign ft_bus = !ft_oe_n ? host_byte : 8'hzz;

   task automatic abort_run();
      $display("test failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual,
                  expected);
         abort_run();
      end
   endtask

   // 32-bit lcg with the code taken from the middle bits
   function automatic adc_bridge_pkg::adc_code_t next_code();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[25:16];
   endfunction

   // ft232h host model acting on pre-edge strobe values
   always @(posedge clk) begin
      if (!ft_rd_n && !ft_rxf_n && (cmd_q.size() > 0)) begin
         cmd_q.delete(0);
      end
      if (!ft_wr_n && !ft_txe_n) begin
         rx_q.push_back(ft_bus);
      end
      ft_rxf_n <= (cmd_q.size() == 0);
      if (cmd_q.size() > 0) begin
         host_byte <= cmd_q[0];
      end else begin
         host_byte <= 8'h00;
      end
   end

   // mcp3008 model sees dclk edges one clk late
   always @(posedge clk) begin
      if (reset) begin
         prev_cs_n = 1'b1;
         prev_dclk = 1'b1;
         mcp_dout <= 1'b0;
      end else begin
         // cs_n fell so a new frame starts
         if (prev_cs_n && !mcp_cs_n) begin
            rise_cnt   = 0;
            fall_cnt   = 0;
            din_bits   = '0;
            frame_code = next_code();
         end
         if (!mcp_cs_n && prev_dclk && !mcp_dclk) begin
            fall_cnt++;
            // code msb first
            if ((fall_cnt >= FIRST_CODE_PERIOD) &&
                (fall_cnt <= adc_bridge_pkg::ADC_FRAME_CLOCKS)) begin
               mcp_dout <= frame_code[adc_bridge_pkg::ADC_FRAME_CLOCKS - fall_cnt];
            end
         end
         if (!mcp_cs_n && !prev_dclk && mcp_dclk) begin
            rise_cnt++;
            if (rise_cnt <= CMD_BITS) begin
               din_bits = {din_bits[CMD_BITS-2:0], mcp_din};
            end
         end
         // cs_n rose at the end of the frame
         if (!prev_cs_n && mcp_cs_n) begin
            compare_value("dclk periods per frame", rise_cnt,
                          adc_bridge_pkg::ADC_FRAME_CLOCKS);
            compare_value("din start and mode bits", din_bits[4:3], 2'b11);
            frame_chan_q.push_back(din_bits[2:0]);
            frame_code_q.push_back(frame_code);
            mcp_dout <= 1'b0;
         end
         prev_cs_n = mcp_cs_n;
         prev_dclk = mcp_dclk;
      end
   end

   // conversion length in clk cycles
   always @(posedge clk) begin
      if (reset) begin
         conv_cnt = 0;
      end else begin
         if (u_dut.adc_start) begin
            conv_cnt = 0;
         end else begin
            conv_cnt++;
         end
         if (u_dut.adc_done) begin
            compare_value("adc_start to adc_done cycles", conv_cnt, CONV_CYCLES);
         end
      end
   end

   // a failed bound assertion ends the run
   always @(u_dut.u_asserts.fail_count) begin
      if (u_dut.u_asserts.fail_count != 0) begin
         $display("Bound protocol assertion failed at %0t", $time);
         abort_run();
      end
   end

   task automatic wait_rx_count(input int n);
      int cycles;
      cycles = 0;
      while (rx_q.size() < n) begin
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            $display("Timeout at %0t: host got %0d of %0d response bytes", $time,
                     rx_q.size(), n);
            abort_run();
         end
      end
   endtask

   // nothing queued, in flight or buffered
   task automatic wait_quiet();
      int cycles;
      cycles = 0;
      while (!((cmd_q.size() == 0) && !u_dut.rx_valid && u_dut.tx_empty && mcp_cs_n &&
               (u_dut.u_ctrl.state == adc_bridge_pkg::ctrl_idle))) begin
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            $display("Timeout at %0t: bridge never went idle", $time);
            abort_run();
         end
      end
   endtask

   // fifo full and controller holding a result
   task automatic wait_stalled();
      int cycles;
      cycles = 0;
      while (!(u_dut.fifo_full &&
               (u_dut.u_ctrl.state == adc_bridge_pkg::ctrl_push_low))) begin
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            $display("Timeout at %0t: controller never stalled on a full fifo", $time);
            abort_run();
         end
      end
   endtask

   task automatic send_cmd(input adc_bridge_pkg::byte_t cmd);
      @(negedge clk);
      cmd_q.push_back(cmd);
   endtask

   task automatic set_txe(input logic level);
      @(posedge clk);
      ft_txe_n <= level;
   endtask

   // pairs in command order then clear everything
   task automatic check_responses();
      int                        n;
      adc_bridge_pkg::adc_code_t code;
      adc_bridge_pkg::byte_t     high_byte;
      n = exp_chan_q.size();
      compare_value("response byte count", rx_q.size(), 2 * n);
      compare_value("conversion frame count", frame_code_q.size(), n);
      for (int i = 0; i < n; i++) begin
         code      = frame_code_q[i];
         high_byte = {1'b0, exp_chan_q[i], 2'b00, code[9:8]};
         compare_value("din channel bits", frame_chan_q[i], exp_chan_q[i]);
         compare_value("low response byte", rx_q[2*i], code[7:0]);
         compare_value("high response byte", rx_q[2*i+1], high_byte);
      end
      exp_chan_q.delete();
      frame_chan_q.delete();
      frame_code_q.delete();
      rx_q.delete();
   endtask

   task automatic run_single(input adc_bridge_pkg::byte_t cmd);
      exp_chan_q.push_back(cmd[2:0]);
      send_cmd(cmd);
      wait_rx_count(2);
      wait_quiet();
      check_responses();
   endtask

   task automatic test_reset();
      @(negedge clk);
      compare_value("ft_rd_n", ft_rd_n, 1'b1);
      compare_value("ft_wr_n", ft_wr_n, 1'b1);
      compare_value("ft_oe_n", ft_oe_n, 1'b1);
      compare_value("mcp_cs_n", mcp_cs_n, 1'b1);
      compare_value("mcp_dclk", mcp_dclk, 1'b1);
      compare_value("mcp_din", mcp_din, 1'b0);
      compare_value("ft_bus", ft_bus, 8'hzz);
      // host must see nothing in a quiet window
      repeat (50) @(negedge clk);
      compare_value("bytes after reset", rx_q.size(), 0);
      compare_value("ft_wr_n", ft_wr_n, 1'b1);
   endtask

   task automatic test_each_channel();
      for (int ch = 0; ch < 8; ch++) begin
         run_single(8'h10 + 8'(ch));
      end
   endtask

   task automatic test_invalid_commands();
      send_cmd(8'h00);
      send_cmd(8'h18);
      send_cmd(8'hff);
      wait_quiet();
      compare_value("bytes after invalid commands", rx_q.size(), 0);
      compare_value("frames after invalid commands", frame_code_q.size(), 0);
      run_single(8'h15);
   endtask

   task automatic test_back_pressure();
      adc_bridge_pkg::byte_t cmds[6];
      cmds = '{8'h13, 8'h16, 8'h11, 8'h17, 8'h10, 8'h14};
      set_txe(1'b1);
      foreach (cmds[i]) begin
         exp_chan_q.push_back(cmds[i][2:0]);
         send_cmd(cmds[i]);
      end
      // 4 pairs fill the fifo
      // 5th result waits in push_low and 6th command stays in the host
      wait_stalled();
      // first low byte waits on the bus with wr_n low until the host has room
      compare_value("ft_wr_n while txe_n high", ft_wr_n, 1'b0);
      compare_value("ft_bus while txe_n high", ft_bus, frame_code_q[0][7:0]);
      compare_value("commands held in host", cmd_q.size(), 1);
      set_txe(1'b0);
      wait_rx_count(12);
      wait_quiet();
      check_responses();
   endtask

   initial begin
      reset     = 1'b1;
      ft_rxf_n  = 1'b1;
      ft_txe_n  = 1'b0;
      mcp_dout  = 1'b0;
      host_byte = 8'h00;
      lcg_state = 32'd87087;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      test_reset();
      test_each_channel();
      test_invalid_commands();
      test_back_pressure();
      $display("test passed");
      $finish;
   end

endmodule

// ==== sim.f ====
hdl/adc_bridge_pkg.sv
hdl/ft245_port.sv
hdl/byte_fifo.sv
hdl/mcp3008_reader.sv
hdl/cmd_controller.sv
hdl/adc_bridge_top.sv
sim/adc_bridge_asserts.sv
sim/tb_adc_bridge.sv
